//--- ppu_pkg.sv
/* ppu shared types and constants */

`default_nettype none

package ppu_pkg;

    typedef logic [7:0]  byte_t;        // cpu / vram data byte
    typedef logic [8:0]  dot_t;         // dot or scanline coordinate
    typedef logic [13:0] vram_addr_t;   // vram address space
    typedef logic [2:0]  reg_sel_t;     // cpu register select

    // cpu register window, in 2c02 order
    localparam reg_sel_t REG_PPUCTRL   = 3'd0;
    localparam reg_sel_t REG_PPUMASK   = 3'd1;
    localparam reg_sel_t REG_PPUSTATUS = 3'd2;
    localparam reg_sel_t REG_OAMADDR   = 3'd3;
    localparam reg_sel_t REG_OAMDATA   = 3'd4;
    localparam reg_sel_t REG_PPUSCROLL = 3'd5;
    localparam reg_sel_t REG_PPUADDR   = 3'd6;
    localparam reg_sel_t REG_PPUDATA   = 3'd7;

    // addresses from here up hit the palette, low 5 bits pick the entry
    localparam vram_addr_t PALETTE_BASE = 14'h3F00;

    // ppuctrl bit positions
    localparam int CTRL_INC32_BIT = 2;   // address step 32 instead of 1
    localparam int CTRL_NMI_BIT   = 7;   // nmi on vblank

    // external vram strobe sequencing
    typedef enum logic [1:0] {
        VRAM_IDLE  = 2'd0,
        VRAM_WRITE = 2'd1,
        VRAM_READ  = 2'd2
    } vram_state_e;

endpackage

`default_nettype wire

//--- ppu_timing.sv
/* dot and scanline counter */

`default_nettype none

module ppu_timing
    import ppu_pkg::*;
#(
    parameter int DOTS_PER_LINE   = 341,
    parameter int LINES_PER_FRAME = 262,
    parameter int VISIBLE_DOTS    = 256,
    parameter int VISIBLE_LINES   = 240,
    parameter int VBLANK_LINE     = 242
)
(
    input  wire  i_clk,
    input  wire  i_reset_n,
    output dot_t o_x,
    output dot_t o_y,
    output logic o_visible,
    output logic o_vblank_set,
    output logic o_vblank_clear
);

    dot_t r_x;
    dot_t r_y;

    wire w_line_end  = (r_x == dot_t'(DOTS_PER_LINE - 1));
    wire w_frame_end = (r_y == dot_t'(LINES_PER_FRAME - 1));

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_x <= '0;
            r_y <= '0;
        end
        else if (w_line_end)
        begin
            r_x <= '0;
            r_y <= w_frame_end ? dot_t'(0) : r_y + dot_t'(1);   // next line or new frame
        end
        else
        begin
            r_x <= r_x + dot_t'(1);
        end
    end

    assign o_x = r_x;
    assign o_y = r_y;
    assign o_visible = (r_x < dot_t'(VISIBLE_DOTS)) && (r_y < dot_t'(VISIBLE_LINES));

    // edge pulses on the first dot of the line
    assign o_vblank_set   = (r_x == '0) && (r_y == dot_t'(VBLANK_LINE));
    assign o_vblank_clear = (r_x == '0) && w_frame_end;

endmodule

`default_nettype wire

//--- ppu_regs.sv
/* cpu register window */

`default_nettype none

module ppu_regs
    import ppu_pkg::*;
(
    input  wire      i_clk,
    input  wire      i_reset_n,
    input  wire      i_cs_n,
    input  wire      i_rw,              // 1 = read
    input  reg_sel_t i_rs,
    input  byte_t    i_data,
    input  wire      i_vblank_set,
    input  wire      i_vblank_clear,
    input  byte_t    i_oam_rdata,
    input  byte_t    i_ppudata_rdata,
    output byte_t    o_data,
    output logic     o_int_n,
    output byte_t    o_wdata,
    output logic     o_inc32,
    output logic     o_oam_addr_we,
    output logic     o_oam_data_we,
    output logic     o_addr_write_hi,
    output logic     o_addr_write_lo,
    output logic     o_data_write,
    output logic     o_data_read
);

    byte_t r_ppuctrl;
    byte_t r_ppumask;       // kept for software, rendering is not part of this core
    logic  r_toggle;        // shared first/second write latch
    logic  r_vblank;

    wire w_write = !i_cs_n && !i_rw;
    wire w_read  = !i_cs_n && i_rw;

    wire w_status_read = w_read && (i_rs == REG_PPUSTATUS);
    wire w_scroll_wr   = w_write && (i_rs == REG_PPUSCROLL);
    wire w_addr_wr     = w_write && (i_rs == REG_PPUADDR);

    // control registers and write toggle
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_ppuctrl <= '0;
            r_ppumask <= '0;
            r_toggle  <= 1'b0;
        end
        else
        begin
            if (w_write && (i_rs == REG_PPUCTRL))
            begin
                r_ppuctrl <= i_data;
            end
            if (w_write && (i_rs == REG_PPUMASK))
            begin
                r_ppumask <= i_data;
            end

            if (w_status_read)
            begin
                r_toggle <= 1'b0;
            end
            else if (w_scroll_wr || w_addr_wr)
            begin
                r_toggle <= !r_toggle;      // scroll data itself is dropped
            end
        end
    end

    // vblank flag, a status read wins over the set edge
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_vblank <= 1'b0;
        end
        else if (w_status_read)
        begin
            r_vblank <= 1'b0;
        end
        else if (i_vblank_set)
        begin
            r_vblank <= 1'b1;
        end
        else if (i_vblank_clear)
        begin
            r_vblank <= 1'b0;
        end
    end

    assign o_int_n = !(r_vblank && r_ppuctrl[CTRL_NMI_BIT]);
    assign o_inc32 = r_ppuctrl[CTRL_INC32_BIT];

    // access strobes for the other blocks
    assign o_wdata         = i_data;
    assign o_oam_addr_we   = w_write && (i_rs == REG_OAMADDR);
    assign o_oam_data_we   = w_write && (i_rs == REG_OAMDATA);
    assign o_addr_write_hi = w_addr_wr && !r_toggle;
    assign o_addr_write_lo = w_addr_wr && r_toggle;
    assign o_data_write    = w_write && (i_rs == REG_PPUDATA);
    assign o_data_read     = w_read && (i_rs == REG_PPUDATA);

    // read data mux
    always_comb
    begin
        o_data = '0;
        if (w_read)
        begin
            case (i_rs)
                REG_PPUSTATUS: o_data = {r_vblank, 7'b0};   // low bits read as zero
                REG_OAMDATA:   o_data = i_oam_rdata;
                REG_PPUDATA:   o_data = i_ppudata_rdata;
                default:       o_data = '0;                 // write-only registers
            endcase
        end
    end

endmodule

`default_nettype wire

//--- ppu_oam.sv
/* sprite attribute memory */

`default_nettype none

module ppu_oam
    import ppu_pkg::*;
(
    input  wire   i_clk,
    input  wire   i_reset_n,
    input  wire   i_addr_we,    // oamaddr write
    input  wire   i_data_we,    // oamdata write
    input  byte_t i_wdata,
    output byte_t o_rdata
);

    byte_t r_oam [256];
    byte_t r_oamaddr;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_oamaddr <= '0;
        end
        else if (i_addr_we)
        begin
            r_oamaddr <= i_wdata;
        end
        else if (i_data_we)
        begin
            r_oamaddr <= r_oamaddr + byte_t'(1);    // wraps at 256
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_data_we)
        begin
            r_oam[r_oamaddr] <= i_wdata;
        end
    end

    assign o_rdata = r_oam[r_oamaddr];

endmodule

`default_nettype wire

//--- ppu_palette.sv
/* palette ram */

`default_nettype none

module ppu_palette
    import ppu_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_we,
    input  wire  [4:0] i_index,
    input  byte_t      i_wdata,
    output byte_t      o_rdata
);

    // 4 background + 4 sprite palettes of 4 entries
    byte_t r_palette [32];

    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            r_palette[i_index] <= i_wdata;
        end
    end

    assign o_rdata = r_palette[i_index];    // same-cycle read for ppudata

endmodule

`default_nettype wire

//--- ppu_vram_port.sv
/* ppudata address, palette and vram port */

`default_nettype none

module ppu_vram_port
    import ppu_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_reset_n,
    input  wire        i_addr_write_hi,
    input  wire        i_addr_write_lo,
    input  wire        i_data_write,
    input  wire        i_data_read,
    input  wire        i_inc32,
    input  byte_t      i_wdata,
    input  byte_t      i_vram_data,
    output byte_t      o_ppudata_rdata,
    output logic       o_vram_rd_n,
    output logic       o_vram_we_n,
    output vram_addr_t o_vram_address,
    output byte_t      o_vram_data
);

    vram_addr_t  r_addr;            // ppuaddr
    vram_addr_t  r_vram_addr;       // held on the bus during a strobe
    byte_t       r_vram_wdata;
    byte_t       r_buffer;          // delayed read buffer
    vram_state_e r_state;
    byte_t       w_pal_rdata;

    wire w_is_palette = (r_addr >= PALETTE_BASE);
    wire w_access     = i_data_write || i_data_read;

    ppu_palette u_palette (
        .i_clk   (i_clk),
        .i_we    (i_data_write && w_is_palette),
        .i_index (r_addr[4:0]),
        .i_wdata (i_wdata),
        .o_rdata (w_pal_rdata)
    );

    // ppuaddr, two byte load and step after each ppudata access
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_addr <= '0;
        end
        else if (i_addr_write_hi)
        begin
            r_addr[13:8] <= i_wdata[5:0];
        end
        else if (i_addr_write_lo)
        begin
            r_addr[7:0] <= i_wdata;
        end
        else if (w_access)
        begin
            r_addr <= r_addr + (i_inc32 ? vram_addr_t'(32) : vram_addr_t'(1));
        end
    end

    // one-cycle strobe after the access, buffer filled at the end of a read strobe
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_state      <= VRAM_IDLE;
            r_vram_addr  <= '0;
            r_vram_wdata <= '0;
            r_buffer     <= '0;
        end
        else
        begin
            case (r_state)
                VRAM_IDLE:
                begin
                    if (w_access && !w_is_palette)
                    begin
                        r_vram_addr  <= r_addr;     // pre-step address
                        r_vram_wdata <= i_wdata;
                        r_state      <= i_data_write ? VRAM_WRITE : VRAM_READ;
                    end
                end
                VRAM_READ:
                begin
                    r_buffer <= i_vram_data;
                    r_state  <= VRAM_IDLE;
                end
                default:
                begin
                    r_state <= VRAM_IDLE;           // write strobe done
                end
            endcase
        end
    end

    assign o_vram_we_n     = (r_state != VRAM_WRITE);
    assign o_vram_rd_n     = (r_state != VRAM_READ);
    assign o_vram_address  = r_vram_addr;
    assign o_vram_data     = o_vram_we_n ? byte_t'(0) : r_vram_wdata;
    assign o_ppudata_rdata = w_is_palette ? w_pal_rdata : r_buffer;

endmodule

`default_nettype wire

//--- ppu.sv
/* ppu cpu-facing core */

`default_nettype none

module ppu
    import ppu_pkg::*;
#(
    parameter int DOTS_PER_LINE   = 341,
    parameter int LINES_PER_FRAME = 262,
    parameter int VISIBLE_DOTS    = 256,
    parameter int VISIBLE_LINES   = 240,
    parameter int VBLANK_LINE     = 242
)
(
    input  wire        i_clk,
    input  wire        i_reset_n,
    input  wire        i_cs_n,          // chip select
    input  wire        i_rw,            // 1 = read
    input  reg_sel_t   i_rs,
    input  byte_t      i_data,
    output byte_t      o_data,
    output logic       o_int_n,         // to cpu nmi
    output logic       o_vram_rd_n,
    output logic       o_vram_we_n,
    output vram_addr_t o_vram_address,
    output byte_t      o_vram_data,
    input  byte_t      i_vram_data,
    output dot_t       o_video_x,
    output dot_t       o_video_y,
    output logic       o_video_visible
);

    logic  w_vblank_set;
    logic  w_vblank_clear;
    byte_t w_wdata;
    logic  w_inc32;
    logic  w_oam_addr_we;
    logic  w_oam_data_we;
    logic  w_addr_write_hi;
    logic  w_addr_write_lo;
    logic  w_data_write;
    logic  w_data_read;
    byte_t w_oam_rdata;
    byte_t w_ppudata_rdata;

    ppu_timing #(
        .DOTS_PER_LINE   (DOTS_PER_LINE),
        .LINES_PER_FRAME (LINES_PER_FRAME),
        .VISIBLE_DOTS    (VISIBLE_DOTS),
        .VISIBLE_LINES   (VISIBLE_LINES),
        .VBLANK_LINE     (VBLANK_LINE)
    ) u_timing (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .o_x            (o_video_x),
        .o_y            (o_video_y),
        .o_visible      (o_video_visible),
        .o_vblank_set   (w_vblank_set),
        .o_vblank_clear (w_vblank_clear)
    );

    ppu_regs u_regs (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_cs_n          (i_cs_n),
        .i_rw            (i_rw),
        .i_rs            (i_rs),
        .i_data          (i_data),
        .i_vblank_set    (w_vblank_set),
        .i_vblank_clear  (w_vblank_clear),
        .i_oam_rdata     (w_oam_rdata),
        .i_ppudata_rdata (w_ppudata_rdata),
        .o_data          (o_data),
        .o_int_n         (o_int_n),
        .o_wdata         (w_wdata),
        .o_inc32         (w_inc32),
        .o_oam_addr_we   (w_oam_addr_we),
        .o_oam_data_we   (w_oam_data_we),
        .o_addr_write_hi (w_addr_write_hi),
        .o_addr_write_lo (w_addr_write_lo),
        .o_data_write    (w_data_write),
        .o_data_read     (w_data_read)
    );

    ppu_oam u_oam (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_addr_we (w_oam_addr_we),
        .i_data_we (w_oam_data_we),
        .i_wdata   (w_wdata),
        .o_rdata   (w_oam_rdata)
    );

    ppu_vram_port u_vram_port (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_addr_write_hi (w_addr_write_hi),
        .i_addr_write_lo (w_addr_write_lo),
        .i_data_write    (w_data_write),
        .i_data_read     (w_data_read),
        .i_inc32         (w_inc32),
        .i_wdata         (w_wdata),
        .i_vram_data     (i_vram_data),
        .o_ppudata_rdata (w_ppudata_rdata),
        .o_vram_rd_n     (o_vram_rd_n),
        .o_vram_we_n     (o_vram_we_n),
        .o_vram_address  (o_vram_address),
        .o_vram_data     (o_vram_data)
    );

endmodule

`default_nettype wire

//--- tb_ppu.sv
/* ppu testbench */

`default_nettype none

module tb_ppu
    import ppu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DOTS        = 20;
    localparam int LINES       = 16;
    localparam int VIS_DOTS    = 12;
    localparam int VIS_LINES   = 10;
    localparam int VBL_LINE    = 12;
    localparam int FRAME       = DOTS * LINES;
    localparam int ACCESSES    = 3000;
    localparam int CYCLE_LIMIT = ACCESSES * 5 + 4 * FRAME;

    localparam int STROBE_NONE  = 0;
    localparam int STROBE_WRITE = 1;
    localparam int STROBE_READ  = 2;

    logic       i_clk;
    logic       i_reset_n;
    logic       i_cs_n;
    logic       i_rw;
    reg_sel_t   i_rs;
    byte_t      i_data;
    byte_t      o_data;
    logic       o_int_n;
    logic       o_vram_rd_n;
    logic       o_vram_we_n;
    vram_addr_t o_vram_address;
    byte_t      o_vram_data;
    byte_t      i_vram_data;
    dot_t       o_video_x;
    dot_t       o_video_y;
    logic       o_video_visible;

    // external vram seen by the dut
    byte_t vram_mem [16384];

    // reference model state
    int         m_x;
    int         m_y;
    byte_t      m_ctrl;
    logic       m_toggle;
    logic       m_vblank;
    vram_addr_t m_addr;
    byte_t      m_buffer;
    byte_t      m_pal [32];
    logic       m_pal_valid [32];
    byte_t      m_oam [256];
    logic       m_oam_valid [256];
    byte_t      m_oamaddr;
    byte_t      m_vram [16384];
    int         m_strobe;
    vram_addr_t m_strobe_addr;
    byte_t      m_strobe_data;

    int errors = 0;
    int checks = 0;
    int cycle_count = 0;

    ppu #(
        .DOTS_PER_LINE   (DOTS),
        .LINES_PER_FRAME (LINES),
        .VISIBLE_DOTS    (VIS_DOTS),
        .VISIBLE_LINES   (VIS_LINES),
        .VBLANK_LINE     (VBL_LINE)
    ) i_ppu (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_cs_n          (i_cs_n),
        .i_rw            (i_rw),
        .i_rs            (i_rs),
        .i_data          (i_data),
        .o_data          (o_data),
        .o_int_n         (o_int_n),
        .o_vram_rd_n     (o_vram_rd_n),
        .o_vram_we_n     (o_vram_we_n),
        .o_vram_address  (o_vram_address),
        .o_vram_data     (o_vram_data),
        .i_vram_data     (i_vram_data),
        .o_video_x       (o_video_x),
        .o_video_y       (o_video_y),
        .o_video_visible (o_video_visible)
    );

    // power-up contents, every address bit takes part
    function automatic byte_t fill_pattern(vram_addr_t a);
        return a[7:0] ^ a[13:6];
    endfunction

    initial
    begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    initial
    begin
        for (int a = 0; a < 16384; a++)
            vram_mem[a] <= fill_pattern(vram_addr_t'(a));
    end

    always @(posedge i_clk)
    begin
        if (!o_vram_we_n)
        begin
            vram_mem[o_vram_address] <= o_vram_data;
        end
    end

    assign i_vram_data = o_vram_rd_n ? 8'h00 : vram_mem[o_vram_address];   // same-cycle answer

    always @(posedge i_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout: sequence still running after %0d cycles", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %s: got %0h expected %0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic reset_model();
        m_x = 0;
        m_y = 0;
        m_ctrl = 8'h00;
        m_toggle = 1'b0;
        m_vblank = 1'b0;
        m_addr = '0;
        m_buffer = 8'h00;
        m_oamaddr = 8'h00;
        m_strobe = STROBE_NONE;
        m_strobe_addr = '0;
        m_strobe_data = 8'h00;
        for (int i = 0; i < 32; i++)
            m_pal_valid[i] = 1'b0;
        for (int i = 0; i < 256; i++)
            m_oam_valid[i] = 1'b0;
        for (int a = 0; a < 16384; a++)
            m_vram[a] = fill_pattern(vram_addr_t'(a));
    endtask

    // expected outputs for the cycle now on the bus
    task automatic check_outputs();
        logic  exp_visible;
        byte_t exp_data;
        logic  data_known;
        exp_visible = (m_x < VIS_DOTS) && (m_y < VIS_LINES);
        exp_data = 8'h00;
        data_known = 1'b1;
        compare_value("o_video_x", 32'(o_video_x), 32'(m_x));
        compare_value("o_video_y", 32'(o_video_y), 32'(m_y));
        compare_value("o_video_visible", 32'(o_video_visible), 32'(exp_visible));
        compare_value("o_int_n", 32'(o_int_n), 32'(!(m_vblank && m_ctrl[7])));
        compare_value("o_vram_we_n", 32'(o_vram_we_n), 32'(m_strobe != STROBE_WRITE));
        compare_value("o_vram_rd_n", 32'(o_vram_rd_n), 32'(m_strobe != STROBE_READ));
        if (m_strobe != STROBE_NONE)
        begin
            compare_value("o_vram_address", 32'(o_vram_address), 32'(m_strobe_addr));
        end
        compare_value("o_vram_data", 32'(o_vram_data),
                      32'((m_strobe == STROBE_WRITE) ? m_strobe_data : 8'h00));

        if (!i_cs_n && i_rw)
        begin
            case (i_rs)
                REG_PPUSTATUS: exp_data = {m_vblank, 7'b0};
                REG_OAMDATA:
                begin
                    data_known = m_oam_valid[m_oamaddr];    // unwritten oam is undefined
                    exp_data = m_oam[m_oamaddr];
                end
                REG_PPUDATA:
                begin
                    if (m_addr[13:8] == 6'h3F)
                    begin
                        data_known = m_pal_valid[m_addr[4:0]];
                        exp_data = m_pal[m_addr[4:0]];
                    end
                    else
                    begin
                        exp_data = m_buffer;                // stale buffer first
                    end
                end
                default: exp_data = 8'h00;
            endcase
        end
        if (data_known)
        begin
            compare_value("o_data", 32'(o_data), 32'(exp_data));
        end
    endtask

    // model state after the coming rising edge
    task automatic advance_model();
        logic wr;
        logic rd;
        logic status_rd;
        logic vb_set;
        logic vb_clr;
        logic to_palette;
        wr = !i_cs_n && !i_rw;
        rd = !i_cs_n && i_rw;
        status_rd = rd && (i_rs == REG_PPUSTATUS);
        vb_set = (m_x == 0) && (m_y == VBL_LINE);
        vb_clr = (m_x == 0) && (m_y == LINES - 1);
        to_palette = (m_addr[13:8] == 6'h3F);

        if (m_strobe == STROBE_WRITE)
            m_vram[m_strobe_addr] = m_strobe_data;
        else if (m_strobe == STROBE_READ)
            m_buffer = m_vram[m_strobe_addr];           // captured at end of strobe
        m_strobe = STROBE_NONE;

        if (status_rd)
            m_vblank = 1'b0;
        else if (vb_set)
            m_vblank = 1'b1;
        else if (vb_clr)
            m_vblank = 1'b0;

        if (status_rd)
            m_toggle = 1'b0;

        if (wr)
        begin
            case (i_rs)
                REG_PPUCTRL: m_ctrl = i_data;
                REG_OAMADDR: m_oamaddr = i_data;
                REG_OAMDATA:
                begin
                    m_oam[m_oamaddr] = i_data;
                    m_oam_valid[m_oamaddr] = 1'b1;
                    m_oamaddr = m_oamaddr + 8'd1;
                end
                REG_PPUSCROLL: m_toggle = !m_toggle;
                REG_PPUADDR:
                begin
                    if (!m_toggle)
                        m_addr = {i_data[5:0], m_addr[7:0]};
                    else
                        m_addr = {m_addr[13:8], i_data};
                    m_toggle = !m_toggle;
                end
                REG_PPUDATA:
                begin
                    if (to_palette)
                    begin
                        m_pal[m_addr[4:0]] = i_data;
                        m_pal_valid[m_addr[4:0]] = 1'b1;
                    end
                    else
                    begin
                        m_strobe = STROBE_WRITE;
                        m_strobe_addr = m_addr;
                        m_strobe_data = i_data;
                    end
                    m_addr = m_addr + (m_ctrl[2] ? 14'd32 : 14'd1);
                end
                default: ;
            endcase
        end
        else if (rd && (i_rs == REG_PPUDATA))
        begin
            if (!to_palette)
            begin
                m_strobe = STROBE_READ;
                m_strobe_addr = m_addr;
            end
            m_addr = m_addr + (m_ctrl[2] ? 14'd32 : 14'd1);
        end

        if (m_x == DOTS - 1)
        begin
            m_x = 0;
            m_y = (m_y == LINES - 1) ? 0 : m_y + 1;
        end
        else
        begin
            m_x = m_x + 1;
        end
    endtask

    // one clock cycle, entered and left 1 ns after a rising edge
    task automatic run_cycle(logic cs_n, logic rw, reg_sel_t rs, byte_t data);
        i_cs_n = cs_n;
        i_rw = rw;
        i_rs = rs;
        i_data = data;
        @(negedge i_clk);
        check_outputs();
        advance_model();
        @(posedge i_clk);
        #1;
    endtask

    // random access, ppuaddr and ppudata favoured
    task automatic pick_access(output reg_sel_t rs, output logic rw, output byte_t data);
        int    pick;
        logic [5:0] hi;
        pick = $urandom_range(0, 11);
        if (pick < 8)
            rs = reg_sel_t'(pick);
        else if (pick < 10)
            rs = REG_PPUADDR;
        else
            rs = REG_PPUDATA;
        rw = 1'($urandom_range(0, 1));
        data = byte_t'($urandom_range(0, 255));
        if (rs == REG_PPUADDR)
        begin
            rw = 1'b0;
            if (!m_toggle)
            begin
                case ($urandom_range(0, 3))
                    0, 1: hi = 6'h3F;                               // palette
                    2:    hi = 6'h20 + 6'($urandom_range(0, 3));    // nametables
                    default: hi = 6'($urandom_range(0, 62));
                endcase
                data = {2'($urandom_range(0, 3)), hi};
            end
            else if ($urandom_range(0, 1) == 0)
            begin
                data = byte_t'($urandom_range(0, 15));   // small low byte for reuse
            end
        end
    endtask

    initial
    begin
        int       seed_init;
        reg_sel_t rs;
        logic     rw;
        byte_t    data;
        int       gap;
        seed_init = $urandom(24);
        i_reset_n = 1'b0;
        i_cs_n = 1'b1;
        i_rw = 1'b1;
        i_rs = REG_PPUCTRL;
        i_data = 8'h00;
        reset_model();
        repeat (4) @(posedge i_clk);
        #1;
        i_reset_n = 1'b1;

        for (int n = 0; n < ACCESSES; n++)
        begin
            pick_access(rs, rw, data);
            run_cycle(1'b0, rw, rs, data);
            gap = $urandom_range(2, 4);
            repeat (gap) run_cycle(1'b1, 1'b1, REG_PPUCTRL, 8'h00);
        end
        repeat (FRAME) run_cycle(1'b1, 1'b1, REG_PPUCTRL, 8'h00);   // one quiet frame

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ppu.f
ppu_pkg.sv
ppu_timing.sv
ppu_regs.sv
ppu_oam.sv
ppu_palette.sv
ppu_vram_port.sv
ppu.sv
tb_ppu.sv

//--- run.sh
#!/bin/sh
# build and run the ppu testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_ppu -f ppu.f -o tb_ppu_sim
./obj_dir/tb_ppu_sim > sim.log 2>&1
cat sim.log

if grep -q '^No errors$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
